// ==== phold_testdata.txt ====
# seed (hex)  end_time (hex)  cycle limit (decimal), one run per line
# seed 0000 exercises the forced nonzero LFSR load
ace1 0020 600
9689 0080 2000
0000 0018 600
5a5a 0100 4000

// ==== phold_sim.f ====
phold_pkg.sv
lfsr.sv
rr_arbiter.sv
event_queue.sv
phold_core.sv
gvt_unit.sv
phold_ctrl.sv
phold_top.sv
phold_assert.sv
phold_checker.sv
phold_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds phold_sim with Verilator and runs it

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module phold_tb \
	-f phold_sim.f -o phold_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# A raised error limit lets the run reach its closing report
./obj_dir/phold_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$log"; then
	exit 1
fi
exit 0

// ==== phold_tb.sv ====
`timescale 1ns/1ps

module phold_tb import phold_pkg::*; ();
	localparam int MAX_RUNS   = 8;
	localparam int GAP_CYCLES = 8;  // Leftover core results drain while idle

	logic            clk;
	logic            rst_n;
	logic            start;
	logic [15:0]     seed;
	logic [TW-1:0]   end_time;
	logic [TW-1:0]   gvt;
	logic            done;
	logic            busy;
	dispatch_trace_t dispatch;
	return_trace_t   retire;

	int              mismatch_cnt;
	int              fail_cnt;
	int              runs_seen;
	logic [15:0]     run_seed  [MAX_RUNS];
	logic [TW-1:0]   run_end   [MAX_RUNS];
	int              run_limit [MAX_RUNS];
	int              n_runs;
	int              cur_run;
	int              cycles;
	int              cycle_limit;
	bit              limit_set;

	phold_top #(.QUEUE_DEPTH(16), .LFSR_SEED_W(16)) i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.seed     (seed),
		.end_time (end_time),
		.gvt      (gvt),
		.done     (done),
		.busy     (busy),
		.dispatch (dispatch),
		.retire   (retire)
	);

	phold_checker i_checker (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.end_time     (end_time),
		.gvt          (gvt),
		.done         (done),
		.busy         (busy),
		.dispatch     (dispatch),
		.retire       (retire),
		.mismatch_cnt (mismatch_cnt),
		.fail_cnt     (fail_cnt),
		.runs_seen    (runs_seen)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit_set && cycles > cycle_limit) begin
			$display("timeout in run %0d after %0d cycles", cur_run, cycles);
			$display("tests failed");
			$finish;
		end
	end

	function automatic bit load_runs();
		int          fd;
		int          lim;
		string       line;
		logic [15:0] s;
		logic [15:0] e;
		n_runs = 0;
		fd = $fopen("phold_testdata.txt", "r");
		if (fd == 0)
			return 1'b0;
		while (!$feof(fd) && n_runs < MAX_RUNS) begin
			if ($fgets(line, fd) > 0 && line.getc(0) != "#" &&
			    $sscanf(line, "%h %h %d", s, e, lim) == 3) begin
				run_seed[n_runs]  = s;
				run_end[n_runs]   = e;
				run_limit[n_runs] = lim;
				n_runs++;
			end
		end
		$fclose(fd);
		return n_runs > 0;
	endfunction

	task automatic run_once(input int r);
		@(negedge clk);
		seed     = run_seed[r];
		end_time = run_end[r];
		start    = 1'b1;
		@(negedge clk);
		start = 1'b0;
		while (done !== 1'b1)
			@(negedge clk);
		repeat (GAP_CYCLES) @(negedge clk);
	endtask

	initial begin : main
		int errors;
		clk      = 1'b0;
		rst_n    = 1'b0;
		start    = 1'b0;
		seed     = '0;
		end_time = '0;
		cur_run  = 0;
		if (!load_runs()) begin
			$display("no runs could be read from phold_testdata.txt");
			$display("tests failed");
			$finish;
		end else begin
			cycle_limit = 4 + n_runs * (GAP_CYCLES + 3);
			for (int r = 0; r < n_runs; r++)
				cycle_limit += run_limit[r];
			limit_set = 1'b1;
			repeat (2) @(posedge clk);
			@(negedge clk);
			rst_n = 1'b1;
			for (int r = 0; r < n_runs; r++) begin
				cur_run = r;
				run_once(r);
			end
			errors = mismatch_cnt + fail_cnt + i_dut.i_assert.fail_cnt;
			$display("runs %0d of %0d, mismatches %0d, failures %0d, assertion failures %0d",
				runs_seen, n_runs, mismatch_cnt, fail_cnt, i_dut.i_assert.fail_cnt);
			if (errors == 0 && runs_seen == n_runs)
				$display("all tests passed");
			else
				$display("tests failed");
			$finish;
		end
	end

endmodule

// ==== phold_checker.sv ====
`timescale 1ns/1ps

module phold_checker import phold_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,
	input  logic [TW-1:0]   end_time,
	input  logic [TW-1:0]   gvt,
	input  logic            done,
	input  logic            busy,
	input  dispatch_trace_t dispatch,
	input  return_trace_t   retire,
	output int              mismatch_cnt,
	output int              fail_cnt,
	output int              runs_seen
);
	event_t               pending [$];  // Queue contents in arrival order
	logic [TW-1:0]        disp_ts [NUM_CORES];
	logic [NUM_CORES-1:0] outstanding;
	int                   n_out;
	int                   init_seen;
	logic                 in_run;
	logic                 after_done;
	logic [TW-1:0]        exp_gvt;
	logic [TW-1:0]        gvt_d1;
	logic [TW-1:0]        gvt_d2;

	function automatic string event_text(input event_t e);
		return $sformatf("lp=%0d ts=%0d", e.lp, e.ts);
	endfunction

	task automatic flag_mismatch(input string sig, input string expv, input string actv);
		$display("MISMATCH time=%0t %s expected %s actual %s", $time, sig, expv, actv);
		mismatch_cnt++;
	endtask

	task automatic note_failure(input string msg);
		$display("ERROR time=%0t %s", $time, msg);
		fail_cnt++;
	endtask

	// Earliest time wins, ties go to the older entry
	function automatic int earliest_index();
		int best;
		best = 0;
		for (int i = 1; i < pending.size(); i++) begin
			if (pending[i].ts < pending[best].ts)
				best = i;
		end
		return best;
	endfunction

	task automatic begin_run();
		pending.delete();
		outstanding = '0;
		n_out       = 0;
		init_seen   = 0;
		exp_gvt     = '0;  // Cleared by start
		gvt_d1      = '0;
		gvt_d2      = '0;
		in_run      = 1'b1;
	endtask

	task automatic check_retire();
		event_t init_evt;
		int     lo;
		int     hi;
		if (init_seen < NUM_INIT_EVENTS) begin
			init_evt.lp = LP_W'(init_seen);
			init_evt.ts = '0;
			if (retire.evt !== init_evt)
				flag_mismatch("retire.evt", event_text(init_evt), event_text(retire.evt));
			if (retire.core !== '0)
				flag_mismatch("retire.core", "0", $sformatf("%0d", retire.core));
			init_seen++;
		end else if (!outstanding[retire.core]) begin
			note_failure($sformatf("core %0d returned an event it was never given", retire.core));
		end else begin
			lo = int'(disp_ts[retire.core]) + 1;
			hi = int'(disp_ts[retire.core]) + 2**DELAY_W;
			if (int'(retire.evt.ts) < lo || int'(retire.evt.ts) > hi)
				flag_mismatch("retire.evt.ts", $sformatf("%0d..%0d", lo, hi),
					$sformatf("%0d", retire.evt.ts));
			outstanding[retire.core] = 1'b0;
			n_out--;
		end
		pending.push_back(retire.evt);
	endtask

	task automatic check_dispatch();
		int     idx;
		event_t exp_evt;
		if (pending.size() == 0) begin
			note_failure("dispatch while the queue should be empty");
		end else begin
			idx     = earliest_index();
			exp_evt = pending[idx];
			if (dispatch.evt !== exp_evt)
				flag_mismatch("dispatch.evt", event_text(exp_evt), event_text(dispatch.evt));
			pending.delete(idx);
		end
		if (outstanding[dispatch.core])
			note_failure($sformatf("dispatch to busy core %0d", dispatch.core));
		n_out++;
		outstanding[dispatch.core] = 1'b1;
		disp_ts[dispatch.core]     = dispatch.evt.ts;
		if (n_out > NUM_CORES)
			note_failure($sformatf("%0d events outstanding in the cores", n_out));
	endtask

	task automatic step_run();
		logic [TW-1:0] min_ts;
		if (gvt !== exp_gvt)
			flag_mismatch("gvt", $sformatf("%0d", exp_gvt), $sformatf("%0d", gvt));
		if (done) begin
			// The compare that stopped the engine saw gvt one cycle back
			if (gvt_d1 <= end_time)
				note_failure($sformatf("done with gvt %0d not above end time %0d",
					gvt_d1, end_time));
			if (gvt_d2 > end_time)
				note_failure("gvt passed the end time without stopping the engine");
			in_run     = 1'b0;
			after_done = 1'b1;
			runs_seen++;
		end else begin
			min_ts = '1;
			for (int i = 0; i < NUM_CORES; i++) begin
				if (outstanding[i] && disp_ts[i] < min_ts)
					min_ts = disp_ts[i];
			end
			if (outstanding != '0)
				exp_gvt = min_ts;  // Held while no core is busy
			gvt_d2 = gvt_d1;
			gvt_d1 = gvt;
			if (retire.valid)
				check_retire();
			if (dispatch.valid)
				check_dispatch();
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_run     = 1'b0;
			after_done = 1'b0;
		end else begin
			if (after_done && busy)
				note_failure("busy still high after done");
			after_done = 1'b0;
			if (start)
				begin_run();
			else if (in_run)
				step_run();
			else if (done)
				note_failure("done pulse outside a run");
		end
	end

endmodule

// ==== phold_assert.sv ====
`timescale 1ns/1ps

module phold_assert import phold_pkg::*; #(
	parameter int QUEUE_DEPTH = 16
) (
	input logic          clk,
	input logic          rst_n,
	input engine_state_e state,
	input logic          enq,
	input logic          deq,
	input logic          done,
	input logic [4:0]    count
);
	int fail_cnt;

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			$error("done high for two cycles in a row");
			fail_cnt++;
		end

	enq_state: assert property (@(posedge clk) disable iff (!rst_n)
		enq |-> (state == ST_INIT || state == ST_RUNNING))
		else begin
			$error("enqueue outside init and running");
			fail_cnt++;
		end

	deq_state: assert property (@(posedge clk) disable iff (!rst_n) deq |-> state == ST_RUNNING)
		else begin
			$error("dequeue outside running");
			fail_cnt++;
		end

	count_bound: assert property (@(posedge clk) disable iff (!rst_n) int'(count) <= QUEUE_DEPTH)
		else begin
			$error("queue count above its depth");
			fail_cnt++;
		end

endmodule

bind phold_top phold_assert #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_assert (
	.clk   (clk),
	.rst_n (rst_n),
	.state (state),
	.enq   (enq),
	.deq   (deq),
	.done  (done),
	.count (q_count)
);

// ==== phold_top.sv ====
`timescale 1ns/1ps

module phold_top import phold_pkg::*; #(
	parameter int QUEUE_DEPTH = 16,
	parameter int LFSR_SEED_W = 16
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  logic [LFSR_SEED_W-1:0] seed,
	input  logic [TW-1:0]          end_time,
	output logic [TW-1:0]          gvt,
	output logic                   done,
	output logic                   busy,
	output dispatch_trace_t        dispatch,
	output return_trace_t          retire
);
	engine_state_e        state;
	logic                 enq;
	logic                 deq;
	logic                 init_phase;
	event_t               enq_evt;
	event_t               head;
	logic [4:0]           q_count;
	logic                 q_nonempty;
	logic [7:0]           rnd;
	logic                 ret_take;

	logic [NUM_CORES-1:0] core_ready;
	logic [NUM_CORES-1:0] core_new_ready;
	logic [NUM_CORES-1:0] core_ack;
	event_t               core_new_evt [NUM_CORES];

	logic [NUM_CORES-1:0] disp_gnt_vec;
	logic [CORE_W-1:0]    disp_idx;
	logic                 core_avail;
	logic [NUM_CORES-1:0] rcv_gnt_vec;
	logic [CORE_W-1:0]    rcv_idx;
	logic                 ret_avail;

	phold_ctrl i_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.end_time   (end_time),
		.gvt        (gvt),
		.q_nonempty (q_nonempty),
		.core_avail (core_avail),
		.ret_avail  (ret_avail),
		.ret_evt    (core_new_evt[rcv_idx]),
		.state      (state),
		.enq        (enq),
		.enq_evt    (enq_evt),
		.deq        (deq),
		.init_phase (init_phase),
		.done       (done),
		.busy       (busy)
	);

	event_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
		.clk      (clk),
		.rst_n    (rst_n),
		.clear    (start),
		.enq      (enq),
		.enq_evt  (enq_evt),
		.deq      (deq),
		.head     (head),
		.count    (q_count),
		.nonempty (q_nonempty)
	);

	rr_arbiter i_disp_arb (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (core_ready),
		.en      (deq),
		.gnt_vec (disp_gnt_vec),
		.gnt_idx (disp_idx),
		.any     (core_avail)
	);

	// Leftover results are drained while idle so they stay out of the next run
	assign ret_take = (enq && !init_phase) || (state == ST_IDLE);

	rr_arbiter i_rcv_arb (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (core_new_ready),
		.en      (ret_take),
		.gnt_vec (rcv_gnt_vec),
		.gnt_idx (rcv_idx),
		.any     (ret_avail)
	);

	assign core_ack = rcv_gnt_vec & {NUM_CORES{ret_take}};

	for (genvar g = 0; g < NUM_CORES; g++) begin : gen_core
		phold_core i_core (
			.clk         (clk),
			.rst_n       (rst_n),
			.event_valid (deq && disp_gnt_vec[g]),
			.evt         (head),
			.random_in   (rnd),
			.ready       (core_ready[g]),
			.new_ready   (core_new_ready[g]),
			.new_evt     (core_new_evt[g]),
			.ack         (core_ack[g])
		);
	end

	gvt_unit i_gvt (
		.clk        (clk),
		.rst_n      (rst_n),
		.clear      (start),
		.running    (state == ST_RUNNING),
		.disp_valid (deq),
		.disp_core  (disp_idx),
		.disp_time  (head.ts),
		.ret_valid  (enq && !init_phase),
		.ret_core   (rcv_idx),
		.gvt        (gvt)
	);

	lfsr #(.LFSR_SEED_W(LFSR_SEED_W)) i_lfsr (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (start),
		.seed  (seed),
		.step  (deq || init_phase),
		.rnd   (rnd)
	);

	assign dispatch = '{valid: deq, core: disp_idx, evt: head};
	assign retire   = '{valid: enq, core: init_phase ? '0 : rcv_idx, evt: enq_evt};

endmodule

// ==== phold_ctrl.sv ====
`timescale 1ns/1ps

module phold_ctrl import phold_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          start,
	input  logic [TW-1:0] end_time,
	input  logic [TW-1:0] gvt,
	input  logic          q_nonempty,
	input  logic          core_avail,
	input  logic          ret_avail,
	input  event_t        ret_evt,
	output engine_state_e state,
	output logic          enq,
	output event_t        enq_evt,
	output logic          deq,
	output logic          init_phase,
	output logic          done,
	output logic          busy
);
	logic [LP_W-1:0] init_cnt;  // Also the lp of the init event
	logic            init_last;

	assign init_last = (init_cnt == LP_W'(NUM_INIT_EVENTS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			init_cnt <= '0;
		end else begin
			init_cnt <= (state == ST_INIT) ? init_cnt + LP_W'(1) : '0;
			unique case (state)
				ST_IDLE:     if (start) state <= ST_INIT;
				ST_INIT:     if (init_last) state <= ST_READY;
				ST_READY:    state <= ST_RUNNING;
				ST_RUNNING:  if (gvt > end_time) state <= ST_FINISHED;
				ST_FINISHED: state <= ST_IDLE;
				default:     state <= ST_IDLE;
			endcase
		end
	end

	assign init_phase = (state == ST_INIT);

	// Returning event takes priority over a dispatch
	assign enq     = init_phase || (state == ST_RUNNING && ret_avail);
	assign deq     = (state == ST_RUNNING) && core_avail && q_nonempty && !ret_avail;
	assign enq_evt = init_phase ? event_t'{lp: init_cnt, ts: '0} : ret_evt;

	assign done = (state == ST_FINISHED);
	assign busy = (state != ST_IDLE);

endmodule

// ==== gvt_unit.sv ====
`timescale 1ns/1ps

module gvt_unit import phold_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              clear,
	input  logic              running,
	input  logic              disp_valid,
	input  logic [CORE_W-1:0] disp_core,
	input  logic [TW-1:0]     disp_time,
	input  logic              ret_valid,
	input  logic [CORE_W-1:0] ret_core,
	output logic [TW-1:0]     gvt
);
	logic [TW-1:0]        loc_time [NUM_CORES];
	logic [NUM_CORES-1:0] active;
	logic [TW-1:0]        min_time;

	always_ff @(posedge clk) begin
		if (disp_valid)
			loc_time[disp_core] <= disp_time;
	end

	// Idle cores count as the largest time
	always_comb begin
		min_time = '1;
		for (int i = 0; i < NUM_CORES; i++) begin
			if (active[i] && loc_time[i] < min_time)
				min_time = loc_time[i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= '0;
			gvt    <= '0;
		end else if (clear) begin
			active <= '0;
			gvt    <= '0;
		end else begin
			if (ret_valid)
				active[ret_core] <= 1'b0;
			if (disp_valid)
				active[disp_core] <= 1'b1;
			if (running && active != '0)  // Hold while no core is busy
				gvt <= min_time;
		end
	end

endmodule

// ==== phold_core.sv ====
`timescale 1ns/1ps

module phold_core import phold_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       event_valid,
	input  event_t     evt,
	input  logic [7:0] random_in,
	output logic       ready,
	output logic       new_ready,
	output event_t     new_evt,
	input  logic       ack
);
	core_state_e state;
	event_t      evt_q;
	logic [7:0]  rnd_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CS_IDLE;
		end else begin
			unique case (state)
				CS_IDLE: if (event_valid) state <= CS_CALC;
				CS_CALC: state <= CS_HOLD;
				CS_HOLD: if (ack) state <= CS_IDLE;  // Waits as long as it takes
				default: state <= CS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == CS_IDLE && event_valid) begin
			evt_q <= evt;
			rnd_q <= random_in;
		end
		// 1 to 16 ticks ahead, random target
		if (state == CS_CALC) begin
			new_evt.ts <= evt_q.ts + TW'(1) + TW'(rnd_q[DELAY_W-1:0]);
			new_evt.lp <= rnd_q[7 -: LP_W];
		end
	end

	assign ready     = (state == CS_IDLE);
	assign new_ready = (state == CS_HOLD);

endmodule

// ==== event_queue.sv ====
`timescale 1ns/1ps

module event_queue import phold_pkg::*; #(
	parameter int QUEUE_DEPTH = 16
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       clear,
	input  logic       enq,
	input  event_t     enq_evt,
	input  logic       deq,
	output event_t     head,
	output logic [4:0] count,
	output logic       nonempty
);
	event_t     slots     [QUEUE_DEPTH];
	event_t     shifted   [QUEUE_DEPTH];
	event_t     slots_nxt [QUEUE_DEPTH];
	logic [4:0] cnt_q;
	logic [4:0] cnt_shift;
	logic [4:0] ins_pos;
	logic       do_deq;
	logic       do_enq;

	assign do_deq    = deq && (cnt_q != '0);
	assign cnt_shift = cnt_q - 5'(do_deq);
	assign do_enq    = enq && (cnt_shift < 5'(QUEUE_DEPTH));  // Dropped when full

	always_comb begin
		// Pop slot 0 first
		for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
			shifted[i] = do_deq ? slots[i + 1] : slots[i];
		end
		shifted[QUEUE_DEPTH-1] = slots[QUEUE_DEPTH-1];

		// First slot strictly later than the new event, so ties stay in arrival order
		ins_pos = cnt_shift;
		for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
			if (i < cnt_shift && shifted[i].ts > enq_evt.ts)
				ins_pos = 5'(i);
		end

		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			if (!do_enq || i < ins_pos)
				slots_nxt[i] = shifted[i];
			else if (i == ins_pos)
				slots_nxt[i] = enq_evt;
			else
				slots_nxt[i] = shifted[i - 1];
		end
	end

	always_ff @(posedge clk) begin
		slots <= slots_nxt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else if (clear) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_shift + 5'(do_enq);
		end
	end

	assign head     = slots[0];
	assign count    = cnt_q;
	assign nonempty = (cnt_q != '0);

endmodule

// ==== rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter import phold_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [NUM_CORES-1:0] req,
	input  logic                 en,
	output logic [NUM_CORES-1:0] gnt_vec,
	output logic [CORE_W-1:0]    gnt_idx,
	output logic                 any
);
	logic [CORE_W-1:0] last;

	// Search starts one past the last winner
	always_comb begin
		logic [CORE_W-1:0] idx;
		gnt_vec = '0;
		gnt_idx = '0;
		any     = 1'b0;
		for (int i = 1; i <= NUM_CORES; i++) begin
			idx = last + CORE_W'(i);
			if (!any && req[idx]) begin
				any          = 1'b1;
				gnt_idx      = idx;
				gnt_vec[idx] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last <= CORE_W'(NUM_CORES - 1);  // Core 0 wins first
		end else if (en && any) begin
			last <= gnt_idx;
		end
	end

endmodule

// ==== lfsr.sv ====
`timescale 1ns/1ps

module lfsr #(
	parameter int LFSR_SEED_W = 16
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   load,
	input  logic [LFSR_SEED_W-1:0] seed,
	input  logic                   step,
	output logic [7:0]             rnd
);
	// x^16 + x^14 + x^13 + x^11, right shifting form
	localparam logic [LFSR_SEED_W-1:0] TAPS = LFSR_SEED_W'(16'hB400);

	logic [LFSR_SEED_W-1:0] state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= LFSR_SEED_W'(1);
		end else if (load) begin
			state <= (seed == '0) ? LFSR_SEED_W'(1) : seed;  // All-zero state locks up
		end else if (step) begin
			state <= (state >> 1) ^ (state[0] ? TAPS : '0);
		end
	end

	assign rnd = state[7:0];

endmodule

// ==== phold_pkg.sv ====
package phold_pkg;

	localparam int TW              = 16;
	localparam int LP_W            = 3;  // 8 logical processes
	localparam int CORE_W          = 2;
	localparam int NUM_CORES       = 4;
	localparam int NUM_INIT_EVENTS = 4;
	localparam int DELAY_W         = 4;

	// lp sits above the timestamp
	typedef struct packed {
		logic [LP_W-1:0] lp;
		logic [TW-1:0]   ts;
	} event_t;

	typedef struct packed {
		logic              valid;
		logic [CORE_W-1:0] core;
		event_t            evt;
	} dispatch_trace_t;

	typedef struct packed {
		logic              valid;
		logic [CORE_W-1:0] core;  // Always 0 for init events
		event_t            evt;
	} return_trace_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_INIT,
		ST_READY,
		ST_RUNNING,
		ST_FINISHED
	} engine_state_e;

	typedef enum logic [1:0] {
		CS_IDLE,
		CS_CALC,
		CS_HOLD
	} core_state_e;

endpackage
